//--- Makefile
TOP = tb_dot_matrix

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f design/*.sv testbench/*.sv testbench/*.svh
	verilator --binary -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Test passed" sim.log

lint:
	verilator --lint-only -Wall design/dm_pkg.sv design/pattern_rom.sv \
		design/row_scanner.sv design/frame_latch.sv design/dot_matrix_top.sv \
		--top-module dot_matrix_top

clean:
	rm -rf obj_dir sim.log

//--- design/dm_pkg.sv
package dm_pkg;

    // matrix geometry
    localparam int NUM_ROWS = 8;

    // glyph count, indices from here up are blank
    localparam int NUM_PATTERNS = 12;

    typedef logic [2:0] row_idx_t;

    // colour mode of a request
    typedef enum logic [1:0]
    {
        COLOR_OFF   = 2'd0,
        COLOR_GREEN = 2'd1,
        COLOR_RED   = 2'd2,
        COLOR_AMBER = 2'd3  // red and green together
    } color_t;

    // one display request
    typedef struct packed
    {
        logic [3:0] pattern_idx;
        color_t     color;
    } disp_req_t;

    // pins of the dot matrix
    typedef struct packed
    {
        logic [7:0] row;   // active low, one line on at a time
        logic [7:0] colr;  // red columns, active high
        logic [7:0] colg;  // green columns, active high
    } drive_t;

endpackage

//--- design/dot_matrix_top.sv
`timescale 1ns/1ps

module dot_matrix_top
#(
    parameter int SCAN_DIV = 4
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  dm_pkg::disp_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output dm_pkg::drive_t    drive
);

    import dm_pkg::*;

    disp_req_t  active;
    row_idx_t   row_idx;
    logic       frame_end;
    logic [7:0] col_bits;

    frame_latch u_frame_latch
    (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .frame_end (frame_end),
        .active    (active)
    );

    // glyph lookup for the current row
    pattern_rom u_pattern_rom
    (
        .pattern_idx (active.pattern_idx),
        .row_idx     (row_idx),
        .col_bits    (col_bits)
    );

    row_scanner #(.SCAN_DIV(SCAN_DIV)) u_row_scanner
    (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .color     (active.color),
        .col_bits  (col_bits),
        .row_idx   (row_idx),
        .frame_end (frame_end),
        .drive     (drive)
    );

endmodule

//--- design/frame_latch.sv
`timescale 1ns/1ps

module frame_latch
(
    input  logic              clk,
    input  logic              rst,
    input  dm_pkg::disp_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              frame_end,
    output dm_pkg::disp_req_t active
);

    import dm_pkg::*;

    disp_req_t pend_req;
    logic      pend_full;
    logic      accept;

    assign req_ready = ~pend_full;
    assign accept    = req_valid && req_ready;

    // pending slot state and active request
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pend_full          <= 1'b0;
            active.pattern_idx <= 4'd0;
            active.color       <= COLOR_OFF;
        end
        else if (frame_end && pend_full)
        begin
            active    <= pend_req;  // swap only at frame boundary
            pend_full <= 1'b0;
        end
        else if (accept)
        begin
            pend_full <= 1'b1;
        end
    end

    // pending payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pend_req <= req;
        end
    end

endmodule

//--- design/pattern_rom.sv
`timescale 1ns/1ps

module pattern_rom
(
    input  logic [3:0]       pattern_idx,
    input  dm_pkg::row_idx_t row_idx,
    output logic [7:0]       col_bits
);

    import dm_pkg::*;

    always_comb
    begin
        col_bits = 8'b0000_0000;
        if (int'(pattern_idx) < NUM_PATTERNS)
        begin
            case (pattern_idx)
                // blob, smallest level
                4'd0:
                begin
                    case (row_idx)
                        3'd2, 3'd5: col_bits = 8'b0001_1000;
                        3'd3, 3'd4: col_bits = 8'b0011_1100;
                        default:    col_bits = 8'b0000_0000;
                    endcase
                end
                4'd1:
                begin
                    case (row_idx)
                        3'd2, 3'd5: col_bits = 8'b0011_1000;
                        3'd3, 3'd4: col_bits = 8'b0111_1100;
                        default:    col_bits = 8'b0000_0000;
                    endcase
                end
                4'd2:
                begin
                    case (row_idx)
                        3'd2, 3'd5: col_bits = 8'b0011_1100;
                        3'd3, 3'd4: col_bits = 8'b0111_1110;
                        default:    col_bits = 8'b0000_0000;
                    endcase
                end
                4'd3:
                begin
                    case (row_idx)
                        3'd1, 3'd6:             col_bits = 8'b0011_1100;
                        3'd2, 3'd3, 3'd4, 3'd5: col_bits = 8'b0111_1110;
                        default:                col_bits = 8'b0000_0000;
                    endcase
                end
                // blob, largest level
                4'd4:
                begin
                    case (row_idx)
                        3'd0, 3'd7: col_bits = 8'b0011_1100;
                        3'd1, 3'd6: col_bits = 8'b0111_1110;
                        default:    col_bits = 8'b1111_1111;
                    endcase
                end
                4'd5: col_bits = 8'b1111_1111;  // full frame
                4'd6:
                begin
                    case (row_idx)
                        3'd0:    col_bits = 8'b1100_0011;
                        3'd1:    col_bits = 8'b1110_0011;
                        3'd2:    col_bits = 8'b1111_0001;
                        3'd3:    col_bits = 8'b1110_0011;
                        3'd4:    col_bits = 8'b1100_0111;
                        3'd5:    col_bits = 8'b1110_0111;
                        3'd6:    col_bits = 8'b1111_0111;
                        default: col_bits = 8'b1111_1011;
                    endcase
                end
                4'd7:
                begin
                    case (row_idx)
                        3'd1:    col_bits = 8'b0000_0001;
                        3'd2:    col_bits = 8'b1000_0001;
                        3'd3:    col_bits = 8'b1100_0011;
                        3'd4:    col_bits = 8'b1000_0011;
                        3'd5:    col_bits = 8'b1100_0111;
                        3'd6:    col_bits = 8'b1110_0111;
                        3'd7:    col_bits = 8'b1111_0011;
                        default: col_bits = 8'b0000_0000;
                    endcase
                end
                4'd8:
                begin
                    case (row_idx)
                        3'd1:    col_bits = 8'b0011_1000;
                        3'd2:    col_bits = 8'b0100_0100;
                        3'd3:    col_bits = 8'b0101_1010;
                        3'd4:    col_bits = 8'b0100_1010;
                        3'd5:    col_bits = 8'b0011_0010;
                        3'd6:    col_bits = 8'b1100_0100;
                        3'd7:    col_bits = 8'b0011_1000;
                        default: col_bits = 8'b0000_0000;
                    endcase
                end
                4'd9:
                begin
                    case (row_idx)
                        3'd2:    col_bits = 8'b0110_0000;
                        3'd3:    col_bits = 8'b1111_1100;
                        3'd4:    col_bits = 8'b0011_1111;
                        3'd5:    col_bits = 8'b0011_1110;
                        3'd6:    col_bits = 8'b0001_1100;
                        default: col_bits = 8'b0000_0000;
                    endcase
                end
                // upward arrow
                4'd10:
                begin
                    case (row_idx)
                        3'd2:       col_bits = 8'b0001_1000;
                        3'd3:       col_bits = 8'b0011_1100;
                        3'd4, 3'd5: col_bits = 8'b0111_1110;
                        3'd6, 3'd7: col_bits = 8'b0001_1000;
                        default:    col_bits = 8'b0000_0000;
                    endcase
                end
                // diagonal cross
                4'd11:
                begin
                    case (row_idx)
                        3'd0, 3'd7: col_bits = 8'b1000_0001;
                        3'd1, 3'd6: col_bits = 8'b0100_0010;
                        3'd2, 3'd5: col_bits = 8'b0010_0100;
                        default:    col_bits = 8'b0001_1000;
                    endcase
                end
                default: col_bits = 8'b0000_0000;
            endcase
        end
    end

endmodule

//--- design/row_scanner.sv
`timescale 1ns/1ps

module row_scanner
#(
    parameter int SCAN_DIV = 4
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  dm_pkg::color_t   color,
    input  logic [7:0]       col_bits,
    output dm_pkg::row_idx_t row_idx,
    output logic             frame_end,
    output dm_pkg::drive_t   drive
);

    import dm_pkg::*;

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             row_tick;
    logic             green_on;
    logic             red_on;

    assign row_tick  = (div_cnt == DIV_W'(SCAN_DIV - 1));
    assign frame_end = row_tick && (row_idx == row_idx_t'(NUM_ROWS - 1));

    assign green_on = en && (color == COLOR_GREEN || color == COLOR_AMBER);
    assign red_on   = en && (color == COLOR_RED || color == COLOR_AMBER);

    // clock divider and row counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            row_idx <= '0;
        end
        else if (row_tick)
        begin
            div_cnt <= '0;
            row_idx <= row_idx + 3'd1;  // wraps after row 7
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // rows and columns share one edge, no ghosting
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            drive.row  <= 8'hff;  // all rows off
            drive.colr <= 8'h00;
            drive.colg <= 8'h00;
        end
        else
        begin
            drive.row  <= ~(8'b0000_0001 << row_idx);
            drive.colr <= red_on ? col_bits : 8'h00;
            drive.colg <= green_on ? col_bits : 8'h00;
        end
    end

endmodule

//--- tb.f
+incdir+testbench
design/dm_pkg.sv
design/pattern_rom.sv
design/row_scanner.sv
design/frame_latch.sv
design/dot_matrix_top.sv
testbench/tb_dot_matrix.sv

//--- testbench/dm_ref.svh
`ifndef DM_REF_SVH
`define DM_REF_SVH

// whole glyph as one word, row 0 in the top byte
function automatic logic [63:0] glyph_rows(input int idx);
    case (idx)
        0:       return 64'h0000_183c_3c18_0000;  // blob levels grow from here
        1:       return 64'h0000_387c_7c38_0000;
        2:       return 64'h0000_3c7e_7e3c_0000;
        3:       return 64'h003c_7e7e_7e7e_3c00;
        4:       return 64'h3c7e_ffff_ffff_7e3c;
        5:       return 64'hffff_ffff_ffff_ffff;
        6:       return 64'hc3e3_f1e3_c7e7_f7fb;
        7:       return 64'h0001_81c3_83c7_e7f3;
        8:       return 64'h0038_445a_4a32_c438;
        9:       return 64'h0000_60fc_3f3e_1c00;
        10:      return 64'h0000_183c_7e7e_1818;  // arrow
        11:      return 64'h8142_2418_1824_4281;  // cross
        default: return 64'h0;                    // unused indices stay dark
    endcase
endfunction

function automatic logic [7:0] ref_glyph(input int idx, input int row);
    logic [63:0] g;
    g = glyph_rows(idx);
    return g[8*(NUM_ROWS-1-row) +: 8];
endfunction

// pins expected for one registered row
function automatic drive_t ref_drive(input disp_req_t r, input int row, input logic en_lvl);
    drive_t     d;
    logic [7:0] bits;
    logic       green;
    logic       red;
    bits  = ref_glyph(int'(r.pattern_idx), row);
    green = (r.color == COLOR_GREEN) || (r.color == COLOR_AMBER);
    red   = (r.color == COLOR_RED) || (r.color == COLOR_AMBER);
    d.row      = 8'hff;
    d.row[row] = 1'b0;  // active low
    d.colg     = (en_lvl && green) ? bits : 8'h00;
    d.colr     = (en_lvl && red) ? bits : 8'h00;
    return d;
endfunction

// all rows off, columns dark
function automatic drive_t reset_drive();
    drive_t d;
    d.row  = 8'hff;
    d.colr = 8'h00;
    d.colg = 8'h00;
    return d;
endfunction

// row number from the row line, -1 if not exactly one zero
function automatic int line_to_row(input logic [7:0] line);
    int found;
    found = -1;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
        if (line === (8'hff ^ (8'h01 << i)))
        begin
            found = i;
        end
    end
    return found;
endfunction

`endif

//--- testbench/tb_dot_matrix.sv
`timescale 1ns/1ps

module tb_dot_matrix;

    import dm_pkg::*;

    `include "dm_ref.svh"

    localparam int SCAN_DIV     = 4;
    localparam int FRAME_CYCLES = SCAN_DIV * NUM_ROWS;
    localparam int NUM_RANDOM   = 40;
    // full sweep, the enable request, then the random ones
    localparam int NUM_REQS     = 16 * 4 + 1 + NUM_RANDOM;
    // at most two frames per request, a few more for the enable test and drain
    localparam int TIMEOUT_CYCLES = (NUM_REQS + 8) * 2 * FRAME_CYCLES + 20;

    logic      clk;
    logic      rst;
    logic      en;
    disp_req_t req;
    logic      req_valid;
    logic      req_ready;
    drive_t    drive;

    int        cycles = 0;
    logic      en_toggle;

    // monitor model
    disp_req_t m_active;
    disp_req_t m_pend;
    logic      m_pend_full;
    int        m_row;
    int        m_hold;
    int        last_seen;
    logic      rst_d1 = 1'b1;
    logic      en_d1;
    logic      ready_d1;
    logic      hs_a = 1'b0;
    logic      hs_b = 1'b0;
    disp_req_t req_a;
    disp_req_t req_b;

    dot_matrix_top #(.SCAN_DIV(SCAN_DIV)) u_dut
    (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .drive     (drive)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_drive(input drive_t got, input drive_t exp, input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("CHECK FAILED t=%0t %s expected %h got %h",
                               $time, name, exp, got));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("CHECK FAILED t=%0t %s expected %b got %b",
                               $time, name, exp, got));
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", cycles));
        end
    end

    // drive at negedge holds the result of the last rising edge
    always @(negedge clk)
    begin : monitor
        int seen;
        seen = line_to_row(drive.row);
        if (rst_d1)
        begin
            check_drive(drive, reset_drive(), "drive");
            m_active.pattern_idx = 4'd0;
            m_active.color       = COLOR_OFF;
            m_pend_full = 1'b0;
            m_row       = -1;
            m_hold      = 0;
            last_seen   = -1;
            hs_a        = 1'b0;
        end
        else
        begin
            if (m_row < 0 || m_hold == SCAN_DIV)
            begin
                m_row  = (m_row + 1) % NUM_ROWS;
                m_hold = 1;
            end
            else
            begin
                m_hold = m_hold + 1;
            end
            // row 0 after row 7 means the swap edge was one clock back
            if (seen == 0 && last_seen == NUM_ROWS - 1 && m_pend_full)
            begin
                m_active    = m_pend;
                m_pend_full = 1'b0;
            end
            last_seen = seen;
            check_drive(drive, ref_drive(m_active, m_row, en_d1), "drive");
            if (hs_b)  // handshake from two edges back, same lag as ready_d1
            begin
                m_pend      = req_b;
                m_pend_full = 1'b1;
            end
            check_ready(ready_d1, !m_pend_full, "req_ready");
        end
        hs_b     = hs_a;
        req_b    = req_a;
        hs_a     = req_valid && req_ready && !rst;
        req_a    = req;
        rst_d1   = rst;
        en_d1    = en;
        ready_d1 = req_ready;
    end

    // one clock, inputs change 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
        if (en_toggle && $urandom_range(0, 7) == 0)
        begin
            en = ~en;
        end
    endtask

    task automatic send_req(input int pat, input color_t col);
        req.pattern_idx = 4'(pat);
        req.color       = col;
        req_valid       = 1'b1;
        while (req_ready !== 1'b1)
        begin
            step();
        end
        step();  // transfer edge
        req_valid = 1'b0;
        check_ready(req_ready, 1'b0, "req_ready");
    endtask

    // next frame start, row 7 then row 0
    task automatic wait_frame();
        while (drive.row !== 8'h7f)
        begin
            step();
        end
        while (drive.row !== 8'hfe)
        begin
            step();
        end
    endtask

    // pending consumed, then its frame shown in full
    task automatic wait_idle();
        while (req_ready !== 1'b1)
        begin
            step();
        end
        wait_frame();
    endtask

    initial
    begin
        int gap;
        void'($urandom(32'hc2e5_906e));
        rst       = 1'b1;
        en        = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        en_toggle = 1'b0;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        check_drive(drive, reset_drive(), "drive");
        check_ready(req_ready, 1'b1, "req_ready");

        // every glyph in every colour, back to back
        for (int c = 0; c < 4; c++)
        begin
            for (int p = 0; p < 16; p++)
            begin
                send_req(p, color_t'(c));
            end
        end
        wait_idle();

        // blank and restore a full amber frame
        send_req(5, COLOR_AMBER);
        wait_idle();
        en = 1'b0;
        wait_frame();
        repeat (3) step();
        en = 1'b1;  // mid-row
        wait_frame();

        en_toggle = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            gap = $urandom_range(0, 6);
            repeat (gap) step();
            send_req($urandom_range(0, 15), color_t'($urandom_range(0, 3)));
        end
        en_toggle = 1'b0;
        en        = 1'b1;
        wait_idle();

        $display("Test passed");
        $finish;
    end

endmodule
